//--- verif/bitrate_vectors.txt
# Counter line: s <counter 0-7> <step per cycle> <start value>, counters 0-3 in, 4-7 out
# Access line:  a <r|w|c> <block tag> <offset> <write data> <expected read data>, c = window count
s 0 00000001 00000000
s 1 00000003 00000000
s 2 0f000000 ffffff00
s 3 00000100 00001000
s 4 00000002 00000000
s 5 00000005 00000000
s 6 00000007 00000000
s 7 00000040 00000000
a r 00010 00 00000000 00000010
a r 00010 01 00000000 00000030
a r 00010 02 00000000 f0000000
a r 00010 03 00000000 00001000
a r 00011 00 00000000 00000020
a r 00011 01 00000000 00000050
a r 00011 02 00000000 00000070
a r 00011 03 00000000 00000400
a r 00010 04 00000000 00000001
a c 00010 05 00000000 00000000
a c 00011 05 00000000 00000000
# Disable the input block, then change its steps
a w 00010 04 00000000 00000000
a r 00010 04 00000000 00000000
s 0 00000004 00000000
s 1 00000006 00000000
s 2 0e000000 fffff000
s 3 00000009 00000000
a r 00010 00 00000000 00000010
a r 00010 02 00000000 f0000000
a c 00010 05 00000000 00000000
a w 00010 04 00000001 00000000
a r 00010 00 00000000 00000040
a r 00010 01 00000000 00000060
a r 00010 02 00000000 e0000000
a r 00010 03 00000000 00000090
a c 00010 05 00000000 00000000
a w 00011 00 12345678 00000000
a r 00011 00 00000000 00000020
a r 00020 00 00000000 deadbeef
a w 00020 04 00000001 00000000
a r 00020 05 00000000 deadbeef

//--- flist.f
logic/udp_pkg.sv
logic/byte_rate_meter.sv
logic/bitrate_computator.sv
logic/udp_reg_master.sv
logic/bitrate_monitor_top.sv
verif/bitrate_monitor_tb.sv

//--- Bender.yml
package:
  name: bitrate_monitor

sources:
  - files:
      - logic/udp_pkg.sv
      - logic/byte_rate_meter.sv
      - logic/bitrate_computator.sv
      - logic/udp_reg_master.sv
      - logic/bitrate_monitor_top.sv
  - target: test
    files:
      - verif/bitrate_monitor_tb.sv

//--- verif/bitrate_monitor_tb.sv
// ----------------------------------------------------------------------
// Bitrate monitor testbench
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module bitrate_monitor_tb;
   import udp_pkg::*;

   localparam int WINDOW_CYCLES = 16;
   localparam int MAX_ACK_WAIT  = 8;

   // One line of the vector file
   typedef struct packed {
      logic [7:0]                 kind;
      logic [7:0]                 rw;
      logic [BLOCK_TAG_WIDTH-1:0] tag;
      logic [5:0]                 offset;
      logic [2:0]                 ctr;
      logic [REG_DATA_WIDTH-1:0]  data;
      logic [REG_DATA_WIDTH-1:0]  exp_data;
   } vec_op_t;

   logic         clk = 1'b0;
   logic         rst_n;
   core_req_t    core_req;
   core_resp_t   core_resp;
   port_counts_t in_bytes_pushed;
   port_counts_t out_bytes_pushed;

   vec_op_t      ops[$];
   byte_count_t  cnt[8]       = '{default: '0};
   byte_count_t  step[8]      = '{default: '0};
   byte_count_t  start_val[8] = '{default: '0};
   logic [7:0]   load         = '0;
   int           cyc          = 0;
   logic [1:0]   en_model     = 2'b11;
   int           win_model[2] = '{default: 0};
   int           en_apply_cyc[2] = '{default: -1};
   logic [1:0]   en_apply_val = 2'b11;
   int           snap_cyc     = -1;
   int           snap_blk     = 0;
   int           snap_val     = 0;
   int           n_access     = 0;
   int           n_tests      = 0;
   int           n_errors     = 0;
   bit           loaded       = 1'b0;

   always #50 clk = ~clk;

   bitrate_monitor_top #(.WINDOW_CYCLES(WINDOW_CYCLES)) i_dut (
      .clk              (clk),
      .rst_n            (rst_n),
      .core_req         (core_req),
      .core_resp        (core_resp),
      .in_bytes_pushed  (in_bytes_pushed),
      .out_bytes_pushed (out_bytes_pushed)
   );

   // ----------------------------------------------------------------------
   // Byte counters and window count model
   // ----------------------------------------------------------------------
   always @(negedge clk) begin
      for (int i = 0; i < 8; i++) begin
         cnt[i] <= load[i] ? start_val[i] : cnt[i] + step[i];
      end
      load <= '0;
   end

   always_comb begin
      for (int i = 0; i < NUM_PORTS; i++) begin
         in_bytes_pushed[i]  = cnt[i];
         out_bytes_pushed[i] = cnt[i + NUM_PORTS];
      end
   end

   // Window ends on every multiple of WINDOW_CYCLES after reset
   always @(posedge clk) begin
      if (rst_n) begin
         cyc = cyc + 1;
         for (int b = 0; b < 2; b++) begin
            if ((cyc % WINDOW_CYCLES == 0) && en_model[b])
               win_model[b]++;
            if (cyc == en_apply_cyc[b])
               en_model[b] = en_apply_val[b];
         end
         if (cyc == snap_cyc)
            snap_val = win_model[snap_blk];
      end
   end

   // ----------------------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------------------
   task automatic check_rate(input string name, input byte_count_t got, input byte_count_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
         n_errors++;
      end
   endtask

   task automatic check_word(input string name, input logic [REG_DATA_WIDTH-1:0] got,
                             input logic [REG_DATA_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
         n_errors++;
      end
   endtask

   task automatic check_latency(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
         n_errors++;
      end
   endtask

   // Strobe one register access and check its reply
   task automatic run_access(input int num, input vec_op_t op);
      int    start_cyc;
      int    blk;
      int    errs_before;
      bit    acked;
      string result;
      errs_before = n_errors;
      blk = (op.tag == IN_RATE_BLOCK_TAG) ? 0 : (op.tag == OUT_RATE_BLOCK_TAG) ? 1 : -1;
      // Reads wait two windows so the rates are steady
      if (op.rw == "w")
         @(negedge clk);
      else
         repeat (2 * WINDOW_CYCLES) @(negedge clk);
      start_cyc = cyc;
      core_req.req               = 1'b1;
      core_req.rd_wr_l           = (op.rw != "w");
      core_req.addr.field.tag    = op.tag;
      core_req.addr.field.offset = op.offset;
      core_req.wr_data           = op.data;
      // Input node sees the item two cycles on, output node three
      if (op.rw == "c" && blk >= 0) begin
         snap_cyc = start_cyc + 1 + blk;
         snap_blk = blk;
      end
      if (op.rw == "w" && blk >= 0 && op.offset == CTRL_REG_OFFSET) begin
         en_apply_cyc[blk] = start_cyc + 2 + blk;
         en_apply_val[blk] = op.data[0];
      end
      acked = 1'b0;
      for (int i = 0; i < MAX_ACK_WAIT && !acked; i++) begin
         @(negedge clk);
         core_req.req = 1'b0;
         acked = core_resp.ack;
      end
      if (!acked) begin
         $display("access %0d was never acknowledged within %0d cycles", num, MAX_ACK_WAIT);
         n_errors++;
      end else begin
         check_latency("core_resp.ack latency", cyc - start_cyc, 4);
         if (op.rw == "c")
            check_word("core_resp.rd_data", core_resp.rd_data, snap_val);
         else if (op.rw == "r" && blk >= 0 && op.offset < NUM_PORTS)
            check_rate("core_resp.rd_data", core_resp.rd_data, op.exp_data);
         else if (op.rw == "r")
            check_word("core_resp.rd_data", core_resp.rd_data, op.exp_data);
      end
      n_tests++;
      result = (n_errors == errs_before) ? "ok" : "failed";
      $display("access %0d %c tag %h offset %0d: %s", num, op.rw, op.tag, op.offset, result);
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      int          fd;
      int          n;
      int          num;
      int          f_ctr;
      string       line;
      string       rw_s;
      logic [31:0] f_tag;
      logic [31:0] f_off;
      logic [31:0] f_data;
      logic [31:0] f_exp;
      vec_op_t     op;
      rst_n    = 1'b0;
      core_req = '0;
      fd = $fopen("verif/bitrate_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file verif/bitrate_vectors.txt");
         n_errors++;
      end
      while (fd != 0 && !$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         op = '0;
         if (line.len() > 1 && line[0] != "#") begin
            if (line[0] == "s") begin
               n = $sscanf(line, "s %d %h %h", f_ctr, f_data, f_exp);
               op.ctr = f_ctr[2:0];
            end else begin
               n = $sscanf(line, "a %s %h %h %h %h", rw_s, f_tag, f_off, f_data, f_exp);
               op.rw     = rw_s[0];
               op.tag    = f_tag[BLOCK_TAG_WIDTH-1:0];
               op.offset = f_off[5:0];
               n_access++;
            end
            // Counter lines carry three fields, access lines five
            if (n != ((line[0] == "s") ? 3 : 5)) begin
               $display("a vector line gave only %0d readable fields", n);
               n_errors++;
            end
            op.kind     = line[0];
            op.data     = f_data;
            op.exp_data = f_exp;
            ops.push_back(op);
         end
      end
      if (fd != 0)
         $fclose(fd);
      loaded = 1'b1;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      num = 0;
      foreach (ops[k]) begin
         if (ops[k].kind == "s") begin
            @(posedge clk);
            step[ops[k].ctr]      = ops[k].data;
            start_val[ops[k].ctr] = ops[k].exp_data;
            load[ops[k].ctr]     <= 1'b1;
         end else begin
            num++;
            run_access(num, ops[k]);
         end
      end
      $display("tests %0d, errors %0d", n_tests, n_errors);
      if (n_errors == 0 && n_tests > 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // Budget per access plus reset and a small margin
   initial begin
      wait (loaded);
      #((n_access * (2 * WINDOW_CYCLES + 10) + 8 + 4) * 100);
      $display("watchdog expired before the run finished");
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- logic/bitrate_monitor_top.sv
// ----------------------------------------------------------------------
// Bitrate monitor top level
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module bitrate_monitor_top #(
   parameter int WINDOW_CYCLES = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  udp_pkg::core_req_t    core_req,
   output udp_pkg::core_resp_t   core_resp,
   input  udp_pkg::port_counts_t in_bytes_pushed,
   input  udp_pkg::port_counts_t out_bytes_pushed
);
   import udp_pkg::*;

   // Ring segments, master -> input block -> output block -> master
   reg_ring_t ring_to_in_rate;
   reg_ring_t ring_to_out_rate;
   reg_ring_t ring_to_master;

   udp_reg_master i_reg_master (
      .clk       (clk),
      .rst_n     (rst_n),
      .core_req  (core_req),
      .core_resp (core_resp),
      .ring_out  (ring_to_in_rate),
      .ring_in   (ring_to_master)
   );

   // ----------------------------------------------------------------------
   // Rate blocks
   // ----------------------------------------------------------------------
   bitrate_computator #(
      .WINDOW_CYCLES (WINDOW_CYCLES),
      .BLOCK_TAG     (IN_RATE_BLOCK_TAG)
   ) i_in_rate (
      .clk          (clk),
      .rst_n        (rst_n),
      .bytes_pushed (in_bytes_pushed),
      .ring_in      (ring_to_in_rate),
      .ring_out     (ring_to_out_rate)
   );

   bitrate_computator #(
      .WINDOW_CYCLES (WINDOW_CYCLES),
      .BLOCK_TAG     (OUT_RATE_BLOCK_TAG)
   ) i_out_rate (
      .clk          (clk),
      .rst_n        (rst_n),
      .bytes_pushed (out_bytes_pushed),
      .ring_in      (ring_to_out_rate),
      .ring_out     (ring_to_master)
   );

endmodule

//--- logic/udp_reg_master.sv
// ----------------------------------------------------------------------
// Register ring master
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module udp_reg_master (
   input  logic                clk,
   input  logic                rst_n,
   input  udp_pkg::core_req_t  core_req,
   output udp_pkg::core_resp_t core_resp,
   output udp_pkg::reg_ring_t  ring_out,
   input  udp_pkg::reg_ring_t  ring_in
);
   import udp_pkg::*;

   // Source tag stamped on every request from this master
   localparam logic [REG_SRC_WIDTH-1:0] MASTER_SRC = REG_SRC_WIDTH'(1);

   logic                      pending;
   logic                      reply;
   logic                      resp_ack;
   logic [REG_DATA_WIDTH-1:0] resp_data;

   // Request has come back around the ring
   assign reply = ring_in.req && pending;

   // ----------------------------------------------------------------------
   // Core to ring
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ring_out <= '0;
         pending  <= 1'b0;
      end else begin
         ring_out <= '{req:     core_req.req,
                       ack:     1'b0,
                       rd_wr_l: core_req.rd_wr_l,
                       addr:    core_req.addr,
                       data:    core_req.wr_data,
                       src:     MASTER_SRC};
         if (core_req.req) begin
            pending <= 1'b1;
         end else if (reply) begin
            pending <= 1'b0;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Ring to core
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_ack <= 1'b0;
      end else begin
         resp_ack <= reply;
      end
   end

   // Unclaimed request gets the marker word
   always_ff @(posedge clk) begin
      if (reply) begin
         resp_data <= ring_in.ack ? ring_in.data : NO_REPLY_DATA;
      end
   end

   assign core_resp = '{ack: resp_ack, rd_data: resp_data};

   a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      core_req.req |-> !pending)
      else $error("core strobe while a ring request is outstanding");

   // Nodes must keep the source tag intact
   a_return_src: assert property (@(posedge clk) disable iff (!rst_n)
      ring_in.req |-> (ring_in.src == MASTER_SRC))
      else $error("returning ring item has source %0d", ring_in.src);

endmodule

//--- logic/bitrate_computator.sv
// ----------------------------------------------------------------------
// Bitrate computator ring node
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module bitrate_computator #(
   parameter int WINDOW_CYCLES = 16,
   parameter logic [udp_pkg::BLOCK_TAG_WIDTH-1:0] BLOCK_TAG = udp_pkg::IN_RATE_BLOCK_TAG
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  udp_pkg::port_counts_t bytes_pushed,
   input  udp_pkg::reg_ring_t    ring_in,
   output udp_pkg::reg_ring_t    ring_out
);
   import udp_pkg::*;

   localparam int TIMER_WIDTH = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;

   logic [TIMER_WIDTH-1:0]      window_timer;
   logic                        window_end;
   logic                        sample;
   logic [REG_DATA_WIDTH-1:0]   ctrl_reg;
   logic [REG_DATA_WIDTH-1:0]   window_cnt;
   port_counts_t                rates;
   logic                        claim;
   logic [REG_OFFSET_WIDTH-1:0] offset;
   logic [REG_OFFSET_WIDTH-1:0] rate_sel;
   logic [REG_DATA_WIDTH-1:0]   rd_value;

   // ----------------------------------------------------------------------
   // Measurement window
   // ----------------------------------------------------------------------
   assign window_end = (window_timer == TIMER_WIDTH'(WINDOW_CYCLES - 1));

   // Bit 0 of the control register enables sampling
   assign sample = window_end & ctrl_reg[0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         window_timer <= '0;
         window_cnt   <= '0;
      end else begin
         if (window_end) begin
            window_timer <= '0;
         end else begin
            window_timer <= window_timer + 1'b1;
         end
         // Only enabled windows are counted
         if (sample) begin
            window_cnt <= window_cnt + 1'b1;
         end
      end
   end

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_meter
      byte_rate_meter i_meter (
         .clk    (clk),
         .rst_n  (rst_n),
         .sample (sample),
         .count  (bytes_pushed[i]),
         .rate   (rates[i])
      );
   end

   // ----------------------------------------------------------------------
   // Register access
   // ----------------------------------------------------------------------
   assign offset   = ring_in.addr.field.offset;
   assign rate_sel = offset - RATE_REG_BASE;
   assign claim    = ring_in.req && !ring_in.ack && (ring_in.addr.field.tag == BLOCK_TAG);

   always_comb begin
      rd_value = '0;
      if (rate_sel < REG_OFFSET_WIDTH'(NUM_PORTS)) begin
         rd_value = rates[rate_sel];
      end else if (offset == CTRL_REG_OFFSET) begin
         rd_value = ctrl_reg;
      end else if (offset == WINDOW_CNT_OFFSET) begin
         rd_value = window_cnt;
      end
   end

   // Ring stage, one cycle per node
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_reg <= REG_DATA_WIDTH'(1);
         ring_out <= '0;
      end else begin
         ring_out <= ring_in;
         if (claim) begin
            ring_out.ack <= 1'b1;
            if (ring_in.rd_wr_l) begin
               ring_out.data <= rd_value;
            end else if (offset == CTRL_REG_OFFSET) begin
               ctrl_reg <= ring_in.data;
            end
         end
      end
   end

   // Upstream never acks an item it did not carry
   a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
      ring_in.ack |-> ring_in.req)
      else $error("ring ack without req at block %h", BLOCK_TAG);

endmodule

//--- logic/byte_rate_meter.sv
// ----------------------------------------------------------------------
// Per-port byte rate meter
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module byte_rate_meter (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 sample,
   input  udp_pkg::byte_count_t count,
   output udp_pkg::byte_count_t rate
);
   import udp_pkg::*;

   // Counter value at the previous window end
   byte_count_t snapshot;
   byte_count_t delta;

   // Modulo 2^32 difference, so a wrapped counter still gives the
   // right byte count for the window
   assign delta = count - snapshot;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snapshot <= '0;
         rate     <= '0;
      end else begin
         if (sample) begin
            snapshot <= count;
            rate     <= delta;
         end
      end
   end

endmodule

//--- logic/udp_pkg.sv
// ----------------------------------------------------------------------
// Bitrate monitor shared definitions
// ----------------------------------------------------------------------
package udp_pkg;

   // ----------------------------------------------------------------------
   // Widths
   // ----------------------------------------------------------------------
   localparam int NUM_PORTS        = 4;
   localparam int REG_ADDR_WIDTH   = 23;
   localparam int REG_DATA_WIDTH   = 32;
   localparam int REG_SRC_WIDTH    = 2;
   localparam int BLOCK_TAG_WIDTH  = 17;
   localparam int REG_OFFSET_WIDTH = REG_ADDR_WIDTH - BLOCK_TAG_WIDTH;

   // Block tags of the two computators
   localparam logic [BLOCK_TAG_WIDTH-1:0] IN_RATE_BLOCK_TAG  = 17'h00010;
   localparam logic [BLOCK_TAG_WIDTH-1:0] OUT_RATE_BLOCK_TAG = 17'h00011;

   // Register map inside one block
   localparam logic [REG_OFFSET_WIDTH-1:0] RATE_REG_BASE     = 6'd0;
   localparam logic [REG_OFFSET_WIDTH-1:0] CTRL_REG_OFFSET   = 6'd4;
   localparam logic [REG_OFFSET_WIDTH-1:0] WINDOW_CNT_OFFSET = 6'd5;

   // Returned when no node claims a request
   localparam logic [REG_DATA_WIDTH-1:0] NO_REPLY_DATA = 32'hDEADBEEF;

   // ----------------------------------------------------------------------
   // Types
   // ----------------------------------------------------------------------
   typedef logic [REG_DATA_WIDTH-1:0] byte_count_t;
   typedef byte_count_t [NUM_PORTS-1:0] port_counts_t;

   typedef struct packed {
      logic [BLOCK_TAG_WIDTH-1:0]  tag;
      logic [REG_OFFSET_WIDTH-1:0] offset;
   } reg_addr_fields_t;

   // Ring address, raw or split into block tag and offset
   typedef union packed {
      logic [REG_ADDR_WIDTH-1:0] raw;
      reg_addr_fields_t          field;
   } reg_addr_u;

   typedef struct packed {
      logic                      req;
      logic                      ack;
      logic                      rd_wr_l;
      reg_addr_u                 addr;
      logic [REG_DATA_WIDTH-1:0] data;
      logic [REG_SRC_WIDTH-1:0]  src;
   } reg_ring_t;

   typedef struct packed {
      logic                      req;
      logic                      rd_wr_l;
      reg_addr_u                 addr;
      logic [REG_DATA_WIDTH-1:0] wr_data;
   } core_req_t;

   typedef struct packed {
      logic                      ack;
      logic [REG_DATA_WIDTH-1:0] rd_data;
   } core_resp_t;

endpackage
